/* hw/cachePkg.sv */
package cachePkg;

  // geometry shared by both caches
  localparam int NumSets   = 16;
  localparam int LineWords = 4;
  localparam int NumWays   = 2;

  // byte address split into offset, index and tag
  localparam int OffsetBits = 4;
  localparam int IndexBits  = 4;
  localparam int TagBits    = 24;

  typedef logic [31:0] addrT;
  typedef logic [31:0] wordT;
  typedef logic [3:0] strbT;
  typedef logic [TagBits-1:0] tagT;
  typedef logic [IndexBits-1:0] indexT;
  typedef logic [LineWords*32-1:0] lineT;

endpackage

/* hw/busPkg.sv */
package busPkg;

  // memory spans 4 KB and upper address bits wrap
  localparam int MemWords   = 1024;
  localparam int MemIdxBits = 10;

  // word i starts out as (i * 4) ^ InitXor
  localparam logic [31:0] InitXor = 32'hA5C3_0F96;

  // 0 selects the data cache, 1 the instruction cache
  typedef logic masterT;

endpackage

/* hw/dataCache.sv */
`timescale 1ns/1ps

module dataCache (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            reqValid_i,
  input  logic            reqWrite_i,
  input  cachePkg::addrT  reqAddr_i,
  input  cachePkg::wordT  reqWdata_i,
  input  cachePkg::strbT  reqStrb_i,
  output logic            reqReady_o,
  output logic            respValid_o,
  output cachePkg::wordT  respData_o,
  output logic            dAwValid_o,
  output logic            dWValid_o,
  output logic            dBReady_o,
  output logic            dArValid_o,
  output logic            dRReady_o,
  output cachePkg::addrT  dAwAddr_o,
  output cachePkg::addrT  dArAddr_o,
  output cachePkg::wordT  dWData_o,
  output cachePkg::strbT  dWStrb_o,
  input  logic            dAwReady_i,
  input  logic            dWReady_i,
  input  logic            dBValid_i,
  input  logic            dArReady_i,
  input  logic            dRValid_i,
  input  cachePkg::wordT  dRData_i
);

  typedef enum logic [2:0] {idle, compare, writeBack, fill, refillDone} stateT;

  stateT state, nextState;

  // latched request
  cachePkg::addrT reqAddr;
  logic reqWrite;
  cachePkg::wordT reqWdata;
  cachePkg::strbT reqStrb;

  cachePkg::tagT tagArr [cachePkg::NumWays][cachePkg::NumSets];
  cachePkg::lineT dataArr [cachePkg::NumWays][cachePkg::NumSets];
  logic [cachePkg::NumSets-1:0] validArr [cachePkg::NumWays];
  logic [cachePkg::NumSets-1:0] dirtyArr [cachePkg::NumWays];
  // lru bit names the way to evict next
  logic [cachePkg::NumSets-1:0] lru;

  cachePkg::lineT fillBuf, hitLine, storeLine, installLine;
  cachePkg::wordT hitWord, fillWord;
  cachePkg::tagT tag;
  cachePkg::indexT idx;
  logic [1:0] wordSel, wordCnt;
  logic hit0, hit1, hit, hitWay, victimWay, reqFire;
  logic awDone, wDone, arDone;

  function automatic cachePkg::wordT mergeWord(input cachePkg::wordT oldW,
                                               input cachePkg::wordT newW,
                                               input cachePkg::strbT strb);
    cachePkg::wordT res;
    res = oldW;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = newW[8*b +: 8];
    end
    return res;
  endfunction

  assign tag = reqAddr[cachePkg::OffsetBits+cachePkg::IndexBits +: cachePkg::TagBits];
  assign idx = reqAddr[cachePkg::OffsetBits +: cachePkg::IndexBits];
  assign wordSel = reqAddr[cachePkg::OffsetBits-1:2];

  assign hit0 = validArr[0][idx] && (tagArr[0][idx] == tag);
  assign hit1 = validArr[1][idx] && (tagArr[1][idx] == tag);
  assign hit = hit0 || hit1;
  assign hitWay = hit1;

  assign hitLine = dataArr[hitWay][idx];
  assign hitWord = hitLine[wordSel*32 +: 32];
  assign fillWord = fillBuf[wordSel*32 +: 32];

  // store bytes merged into the hit line or the refilled line
  always_comb begin
    storeLine = hitLine;
    storeLine[wordSel*32 +: 32] = mergeWord(hitWord, reqWdata, reqStrb);
    installLine = fillBuf;
    if (reqWrite) installLine[wordSel*32 +: 32] = mergeWord(fillWord, reqWdata, reqStrb);
  end

  assign reqReady_o = (state == idle) || (state == compare && hit) || (state == refillDone);
  assign respValid_o = (state == compare && hit) || (state == refillDone);
  assign respData_o = (state == compare) ? hitWord : fillWord;
  assign reqFire = reqValid_i && reqReady_o;

  // victim line written back one word per AW/W pair
  assign dAwValid_o = (state == writeBack) && !awDone;
  assign dWValid_o = (state == writeBack) && !wDone;
  assign dAwAddr_o = {tagArr[victimWay][idx], idx, wordCnt, 2'b00};
  assign dWData_o = dataArr[victimWay][idx][wordCnt*32 +: 32];
  assign dWStrb_o = 4'hF;
  assign dBReady_o = 1'b1;

  assign dArValid_o = (state == fill) && !arDone;
  assign dArAddr_o = {tag, idx, wordCnt, 2'b00};
  assign dRReady_o = 1'b1;

  always_comb begin
    nextState = state;
    case (state)
      idle: if (reqValid_i) nextState = compare;
      compare: begin
        if (hit) nextState = reqValid_i ? compare : idle;
        else if (dirtyArr[lru[idx]][idx]) nextState = writeBack;
        else nextState = fill;
      end
      writeBack: if (dBValid_i && wordCnt == 2'd3) nextState = fill;
      fill: if (dRValid_i && wordCnt == 2'd3) nextState = refillDone;
      refillDone: nextState = reqValid_i ? compare : idle;
      default: nextState = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
      wordCnt <= 2'd0;
      awDone <= 1'b0;
      wDone <= 1'b0;
      arDone <= 1'b0;
      victimWay <= 1'b0;
      lru <= '0;
      for (int w = 0; w < cachePkg::NumWays; w++) begin
        validArr[w] <= '0;
        dirtyArr[w] <= '0;
      end
    end else begin
      state <= nextState;
      if (dAwValid_o && dAwReady_i) awDone <= 1'b1;
      if (dWValid_o && dWReady_i) wDone <= 1'b1;
      if (dArValid_o && dArReady_i) arDone <= 1'b1;
      // counter wraps back to zero after each four-beat loop
      if (state == writeBack && dBValid_i) begin
        awDone <= 1'b0;
        wDone <= 1'b0;
        wordCnt <= wordCnt + 2'd1;
      end
      if (state == fill && dRValid_i) begin
        arDone <= 1'b0;
        wordCnt <= wordCnt + 2'd1;
      end
      if (state == compare && !hit) victimWay <= lru[idx];
      if (state == compare && hit) begin
        lru[idx] <= ~hitWay;
        if (reqWrite) dirtyArr[hitWay][idx] <= 1'b1;
      end
      if (state == refillDone) begin
        validArr[victimWay][idx] <= 1'b1;
        dirtyArr[victimWay][idx] <= reqWrite;
        lru[idx] <= ~victimWay;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reqFire) begin
      reqAddr <= reqAddr_i;
      reqWrite <= reqWrite_i;
      reqWdata <= reqWdata_i;
      reqStrb <= reqStrb_i;
    end
    if (state == fill && dRValid_i) fillBuf[wordCnt*32 +: 32] <= dRData_i;
    if (state == compare && hit && reqWrite) dataArr[hitWay][idx] <= storeLine;
    if (state == refillDone) begin
      dataArr[victimWay][idx] <= installLine;
      tagArr[victimWay][idx] <= tag;
    end
  end

endmodule

/* hw/instrCache.sv */
`timescale 1ns/1ps

module instrCache (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            fetchValid_i,
  input  cachePkg::addrT  fetchAddr_i,
  output logic            fetchReady_o,
  output logic            instrValid_o,
  output cachePkg::wordT  instrData_o,
  output logic            iArValid_o,
  output logic            iRReady_o,
  output cachePkg::addrT  iArAddr_o,
  input  logic            iArReady_i,
  input  logic            iRValid_i,
  input  cachePkg::wordT  iRData_i
);

  typedef enum logic [1:0] {idle, compare, fill} stateT;

  stateT state, nextState;
  cachePkg::addrT fetchAddr;
  cachePkg::tagT tagArr [cachePkg::NumSets];
  cachePkg::lineT lineArr [cachePkg::NumSets];
  logic [cachePkg::NumSets-1:0] validArr;
  cachePkg::tagT tag;
  cachePkg::indexT idx;
  logic [1:0] wordSel, wordCnt;
  logic hit, arDone;

  assign tag = fetchAddr[cachePkg::OffsetBits+cachePkg::IndexBits +: cachePkg::TagBits];
  assign idx = fetchAddr[cachePkg::OffsetBits +: cachePkg::IndexBits];
  assign wordSel = fetchAddr[cachePkg::OffsetBits-1:2];
  assign hit = validArr[idx] && (tagArr[idx] == tag);

  // after a fill the same fetch is looked up again and hits
  assign fetchReady_o = (state == idle) || (state == compare && hit);
  assign instrValid_o = (state == compare) && hit;
  assign instrData_o = lineArr[idx][wordSel*32 +: 32];

  assign iArValid_o = (state == fill) && !arDone;
  assign iArAddr_o = {tag, idx, wordCnt, 2'b00};
  assign iRReady_o = 1'b1;

  always_comb begin
    nextState = state;
    case (state)
      idle: if (fetchValid_i) nextState = compare;
      compare: begin
        if (hit) nextState = fetchValid_i ? compare : idle;
        else nextState = fill;
      end
      fill: if (iRValid_i && wordCnt == 2'd3) nextState = compare;
      default: nextState = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
      wordCnt <= 2'd0;
      arDone <= 1'b0;
      validArr <= '0;
    end else begin
      state <= nextState;
      if (iArValid_o && iArReady_i) arDone <= 1'b1;
      if (state == fill && iRValid_i) begin
        arDone <= 1'b0;
        wordCnt <= wordCnt + 2'd1;
        if (wordCnt == 2'd3) validArr[idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetchValid_i && fetchReady_o) fetchAddr <= fetchAddr_i;
    if (state == fill && iRValid_i) begin
      lineArr[idx][wordCnt*32 +: 32] <= iRData_i;
      if (wordCnt == 2'd3) tagArr[idx] <= tag;
    end
  end

endmodule

/* hw/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter (
  input  logic            clk,
  input  logic            rst_n,
  // data cache side
  input  logic            dArValid_i,
  output logic            dArReady_o,
  input  cachePkg::addrT  dArAddr_i,
  output logic            dRValid_o,
  input  logic            dRReady_i,
  output cachePkg::wordT  dRData_o,
  input  logic            dAwValid_i,
  output logic            dAwReady_o,
  input  cachePkg::addrT  dAwAddr_i,
  input  logic            dWValid_i,
  output logic            dWReady_o,
  input  cachePkg::wordT  dWData_i,
  input  cachePkg::strbT  dWStrb_i,
  output logic            dBValid_o,
  input  logic            dBReady_i,
  // instruction cache side
  input  logic            iArValid_i,
  output logic            iArReady_o,
  input  cachePkg::addrT  iArAddr_i,
  output logic            iRValid_o,
  input  logic            iRReady_i,
  output cachePkg::wordT  iRData_o,
  // merged port toward memory
  output logic            mArValid_o,
  input  logic            mArReady_i,
  output cachePkg::addrT  mArAddr_o,
  input  logic            mRValid_i,
  output logic            mRReady_o,
  input  cachePkg::wordT  mRData_i,
  output logic            mAwValid_o,
  input  logic            mAwReady_i,
  output cachePkg::addrT  mAwAddr_o,
  output logic            mWValid_o,
  input  logic            mWReady_i,
  output cachePkg::wordT  mWData_o,
  output cachePkg::strbT  mWStrb_o,
  input  logic            mBValid_i,
  output logic            mBReady_o
);

  busPkg::masterT owner, grant, prio;
  logic busy, dReq, iReq, addrFire, respFire, isInstr;

  assign dReq = dArValid_i || dAwValid_i || dWValid_i;
  assign iReq = iArValid_i;

  // while idle the grant follows requests and prio breaks ties
  always_comb begin
    if (busy) grant = owner;
    else if (dReq && iReq) grant = prio;
    else grant = iReq;
  end
  assign isInstr = grant;

  assign mArValid_o = isInstr ? iArValid_i : dArValid_i;
  assign mArAddr_o = isInstr ? iArAddr_i : dArAddr_i;
  assign mRReady_o = isInstr ? iRReady_i : dRReady_i;
  assign mAwValid_o = !isInstr && dAwValid_i;
  assign mAwAddr_o = dAwAddr_i;
  assign mWValid_o = !isInstr && dWValid_i;
  assign mWData_o = dWData_i;
  assign mWStrb_o = dWStrb_i;
  assign mBReady_o = !isInstr && dBReady_i;

  assign dArReady_o = !isInstr && mArReady_i;
  assign dRValid_o = !isInstr && mRValid_i;
  assign dRData_o = mRData_i;
  assign dAwReady_o = !isInstr && mAwReady_i;
  assign dWReady_o = !isInstr && mWReady_i;
  assign dBValid_o = !isInstr && mBValid_i;
  assign iArReady_o = isInstr && mArReady_i;
  assign iRValid_o = isInstr && mRValid_i;
  assign iRData_o = mRData_i;

  assign addrFire = (mArValid_o && mArReady_i) || (mAwValid_o && mAwReady_i);
  assign respFire = (mRValid_i && mRReady_o) || (mBValid_i && mBReady_o);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      owner <= 1'b0;
      prio <= 1'b0;
    end else if (respFire) begin
      busy <= 1'b0;
      // the other master wins the next tie
      prio <= ~owner;
    end else if (addrFire && !busy) begin
      busy <= 1'b1;
      owner <= grant;
    end
  end

endmodule

/* hw/wordMemory.sv */
`timescale 1ns/1ps

module wordMemory (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            mArValid_i,
  input  logic            mAwValid_i,
  input  logic            mWValid_i,
  input  logic            mRReady_i,
  input  logic            mBReady_i,
  input  cachePkg::addrT  mArAddr_i,
  input  cachePkg::addrT  mAwAddr_i,
  input  cachePkg::wordT  mWData_i,
  input  cachePkg::strbT  mWStrb_i,
  output logic            mArReady_o,
  output logic            mAwReady_o,
  output logic            mWReady_o,
  output logic            mRValid_o,
  output logic            mBValid_o,
  output cachePkg::wordT  mRData_o
);

  cachePkg::wordT mem [busPkg::MemWords];
  logic [busPkg::MemIdxBits-1:0] rdIdx, wrIdx;

  assign mArReady_o = 1'b1;
  assign mAwReady_o = 1'b1;
  assign mWReady_o = 1'b1;

  assign rdIdx = mArAddr_i[busPkg::MemIdxBits+1:2];
  assign wrIdx = mAwAddr_i[busPkg::MemIdxBits+1:2];

  // contents restart from the xor rule on every reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mRValid_o <= 1'b0;
      mBValid_o <= 1'b0;
      for (int i = 0; i < busPkg::MemWords; i++) begin
        mem[i] <= cachePkg::wordT'(i * 4) ^ busPkg::InitXor;
      end
    end else begin
      if (mRValid_o && mRReady_i) mRValid_o <= 1'b0;
      if (mBValid_o && mBReady_i) mBValid_o <= 1'b0;
      if (mArValid_i) begin
        mRValid_o <= 1'b1;
        mRData_o <= mem[rdIdx];
      end
      // address and data arrive together from the data cache
      if (mAwValid_i && mWValid_i) begin
        mBValid_o <= 1'b1;
        for (int b = 0; b < 4; b++) begin
          if (mWStrb_i[b]) mem[wrIdx][8*b +: 8] <= mWData_i[8*b +: 8];
        end
      end
    end
  end

endmodule

/* hw/cacheTop.sv */
`timescale 1ns/1ps

module cacheTop (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            reqValid_i,
  output logic            reqReady_o,
  input  logic            reqWrite_i,
  input  cachePkg::addrT  reqAddr_i,
  input  cachePkg::wordT  reqWdata_i,
  input  cachePkg::strbT  reqStrb_i,
  output logic            respValid_o,
  output cachePkg::wordT  respData_o,
  input  logic            fetchValid_i,
  output logic            fetchReady_o,
  input  cachePkg::addrT  fetchAddr_i,
  output logic            instrValid_o,
  output cachePkg::wordT  instrData_o
);

  logic dArValid, dArReady, dRValid, dRReady, dAwValid, dAwReady;
  logic dWValid, dWReady, dBValid, dBReady;
  cachePkg::addrT dArAddr, dAwAddr;
  cachePkg::wordT dRData, dWData;
  cachePkg::strbT dWStrb;
  logic iArValid, iArReady, iRValid, iRReady;
  cachePkg::addrT iArAddr;
  cachePkg::wordT iRData;
  logic mArValid, mArReady, mRValid, mRReady, mAwValid, mAwReady;
  logic mWValid, mWReady, mBValid, mBReady;
  cachePkg::addrT mArAddr, mAwAddr;
  cachePkg::wordT mRData, mWData;
  cachePkg::strbT mWStrb;

  dataCache dCache (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid_i), .reqWrite_i(reqWrite_i), .reqAddr_i(reqAddr_i),
    .reqWdata_i(reqWdata_i), .reqStrb_i(reqStrb_i), .reqReady_o(reqReady_o),
    .respValid_o(respValid_o), .respData_o(respData_o),
    .dAwValid_o(dAwValid), .dWValid_o(dWValid), .dBReady_o(dBReady),
    .dArValid_o(dArValid), .dRReady_o(dRReady), .dAwAddr_o(dAwAddr),
    .dArAddr_o(dArAddr), .dWData_o(dWData), .dWStrb_o(dWStrb),
    .dAwReady_i(dAwReady), .dWReady_i(dWReady), .dBValid_i(dBValid),
    .dArReady_i(dArReady), .dRValid_i(dRValid), .dRData_i(dRData)
  );

  instrCache iCache (
    .clk(clk), .rst_n(rst_n),
    .fetchValid_i(fetchValid_i), .fetchAddr_i(fetchAddr_i),
    .fetchReady_o(fetchReady_o), .instrValid_o(instrValid_o), .instrData_o(instrData_o),
    .iArValid_o(iArValid), .iRReady_o(iRReady), .iArAddr_o(iArAddr),
    .iArReady_i(iArReady), .iRValid_i(iRValid), .iRData_i(iRData)
  );

  busArbiter arbiter (
    .clk(clk), .rst_n(rst_n),
    .dArValid_i(dArValid), .dArReady_o(dArReady), .dArAddr_i(dArAddr),
    .dRValid_o(dRValid), .dRReady_i(dRReady), .dRData_o(dRData),
    .dAwValid_i(dAwValid), .dAwReady_o(dAwReady), .dAwAddr_i(dAwAddr),
    .dWValid_i(dWValid), .dWReady_o(dWReady), .dWData_i(dWData), .dWStrb_i(dWStrb),
    .dBValid_o(dBValid), .dBReady_i(dBReady),
    .iArValid_i(iArValid), .iArReady_o(iArReady), .iArAddr_i(iArAddr),
    .iRValid_o(iRValid), .iRReady_i(iRReady), .iRData_o(iRData),
    .mArValid_o(mArValid), .mArReady_i(mArReady), .mArAddr_o(mArAddr),
    .mRValid_i(mRValid), .mRReady_o(mRReady), .mRData_i(mRData),
    .mAwValid_o(mAwValid), .mAwReady_i(mAwReady), .mAwAddr_o(mAwAddr),
    .mWValid_o(mWValid), .mWReady_i(mWReady), .mWData_o(mWData), .mWStrb_o(mWStrb),
    .mBValid_i(mBValid), .mBReady_o(mBReady)
  );

  wordMemory memory (
    .clk(clk), .rst_n(rst_n),
    .mArValid_i(mArValid), .mAwValid_i(mAwValid), .mWValid_i(mWValid),
    .mRReady_i(mRReady), .mBReady_i(mBReady), .mArAddr_i(mArAddr),
    .mAwAddr_i(mAwAddr), .mWData_i(mWData), .mWStrb_i(mWStrb),
    .mArReady_o(mArReady), .mAwReady_o(mAwReady), .mWReady_o(mWReady),
    .mRValid_o(mRValid), .mBValid_o(mBValid), .mRData_o(mRData)
  );

endmodule

/* tb/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic rst_n
);

  localparam int ResetCycles = 10;

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // release lines up with the stimulus drive point
  initial begin
    rst_n = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

/* tb/cacheTb.sv */
`timescale 1ns/1ps

module cacheTb;

  localparam int Timeout = 200;
  localparam int FetchTests = 200;
  localparam int DataTests = 400;
  localparam int MixedTests = 150;

  logic clk, rst_n;
  logic reqValid, reqWrite, reqReady, respValid;
  cachePkg::addrT reqAddr;
  cachePkg::wordT reqWdata, respData;
  cachePkg::strbT reqStrb;
  logic fetchValid, fetchReady, instrValid;
  cachePkg::addrT fetchAddr;
  cachePkg::wordT instrData;

  // reference memory with the same start contents as the DUT memory
  cachePkg::wordT model [busPkg::MemWords];
  int passCnt = 0;
  int failCnt = 0;

  clockGen clocks (.clk(clk), .rst_n(rst_n));

  cacheTop DUT (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid), .reqReady_o(reqReady), .reqWrite_i(reqWrite),
    .reqAddr_i(reqAddr), .reqWdata_i(reqWdata), .reqStrb_i(reqStrb),
    .respValid_o(respValid), .respData_o(respData),
    .fetchValid_i(fetchValid), .fetchReady_o(fetchReady), .fetchAddr_i(fetchAddr),
    .instrValid_o(instrValid), .instrData_o(instrData)
  );

  task automatic checkWord(input string what, input cachePkg::addrT addr,
                           input cachePkg::wordT got, input cachePkg::wordT exp);
    assert (got === exp) begin
      passCnt++;
    end else begin
      $display("MISMATCH at %0t: %s at %h gave %h, expected %h", $time, what, addr, got, exp);
      failCnt++;
    end
  endtask

  task automatic checkNoTimeout(input string what, input int cycles);
    assert (cycles < Timeout) else begin
      $display("timeout after %0d cycles: %s", cycles, what);
      failCnt++;
    end
  endtask

  task automatic reportTest(input string name, input int failsBefore);
    $display("test %s: %s", name, (failCnt == failsBefore) ? "passed" : "FAILED");
  endtask

  // byte-wise store into the reference memory
  task automatic storeModel(input cachePkg::addrT addr, input cachePkg::wordT wdata,
                            input cachePkg::strbT strb);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) model[addr[busPkg::MemIdxBits+1:2]][8*b +: 8] = wdata[8*b +: 8];
    end
  endtask

  function automatic cachePkg::addrT randomDataAddr();
    return cachePkg::addrT'((512 + $urandom_range(0, 511)) * 4);
  endfunction

  function automatic cachePkg::addrT randomFetchAddr();
    return cachePkg::addrT'($urandom_range(0, 511) * 4);
  endfunction

  // latency counts cycles from the accepting edge to the sampled response
  task automatic dataAccess(input logic write, input cachePkg::addrT addr,
                            input cachePkg::wordT wdata, input cachePkg::strbT strb,
                            output cachePkg::wordT rdata, output int latency);
    int cycles;
    @(posedge clk);
    #1;
    reqValid = 1'b1;
    reqWrite = write;
    reqAddr = addr;
    reqWdata = wdata;
    reqStrb = strb;
    cycles = 0;
    @(negedge clk);
    while (!reqReady && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    checkNoTimeout("data request never accepted", cycles);
    @(posedge clk);
    #1;
    reqValid = 1'b0;
    if (write) storeModel(addr, wdata, strb);
    latency = 1;
    @(negedge clk);
    while (!respValid && latency < Timeout) begin
      @(negedge clk);
      latency++;
    end
    checkNoTimeout("data response never arrived", latency);
    rdata = respData;
  endtask

  task automatic fetchWord(input cachePkg::addrT addr, output cachePkg::wordT data);
    int cycles;
    @(posedge clk);
    #1;
    fetchValid = 1'b1;
    fetchAddr = addr;
    cycles = 0;
    @(negedge clk);
    while (!fetchReady && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    checkNoTimeout("fetch never accepted", cycles);
    @(posedge clk);
    #1;
    fetchValid = 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!instrValid && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    checkNoTimeout("instruction never returned", cycles);
    data = instrData;
  endtask

  task automatic runDataTraffic(input int count, input int maxGap);
    logic write;
    cachePkg::addrT addr;
    cachePkg::wordT wdata, rdata;
    cachePkg::strbT strb;
    int latency;
    for (int n = 0; n < count; n++) begin
      write = ($urandom_range(0, 1) == 1);
      addr = randomDataAddr();
      wdata = $urandom();
      strb = cachePkg::strbT'($urandom_range(0, 15));
      dataAccess(write, addr, wdata, strb, rdata, latency);
      if (!write) checkWord("data read", addr, rdata, model[addr[busPkg::MemIdxBits+1:2]]);
      repeat ($urandom_range(0, maxGap)) @(posedge clk);
    end
  endtask

  task automatic runFetchTraffic(input int count, input int maxGap);
    cachePkg::addrT addr;
    cachePkg::wordT data;
    for (int n = 0; n < count; n++) begin
      addr = randomFetchAddr();
      fetchWord(addr, data);
      // low half is never written, so the start rule still holds
      checkWord("fetch", addr, data, addr ^ busPkg::InitXor);
      repeat ($urandom_range(0, maxGap)) @(posedge clk);
    end
  endtask

  initial begin
    int failsBefore;
    int cycles;
    int latency;
    cachePkg::addrT addr;
    cachePkg::wordT rdata;
    void'($urandom(15517));
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr = '0;
    reqWdata = '0;
    reqStrb = '0;
    fetchValid = 1'b0;
    fetchAddr = '0;
    for (int i = 0; i < busPkg::MemWords; i++) begin
      model[i] = cachePkg::wordT'(i * 4) ^ busPkg::InitXor;
    end

    cycles = 0;
    while (rst_n !== 1'b1 && cycles < Timeout) begin
      @(posedge clk);
      cycles++;
    end
    checkNoTimeout("reset never released", cycles);
    @(negedge clk);

    failsBefore = failCnt;
    assert (reqReady && fetchReady && !respValid && !instrValid) begin
      passCnt++;
    end else begin
      $display("MISMATCH at %0t: reset state ready %b/%b valid %b/%b", $time,
               reqReady, fetchReady, respValid, instrValid);
      failCnt++;
    end
    reportTest("reset state", failsBefore);

    failsBefore = failCnt;
    runFetchTraffic(FetchTests, 0);
    reportTest("instruction fetches", failsBefore);

    failsBefore = failCnt;
    runDataTraffic(DataTests, 0);
    reportTest("data traffic", failsBefore);

    // second read of the same word must hit
    failsBefore = failCnt;
    addr = randomDataAddr();
    dataAccess(1'b0, addr, '0, '0, rdata, latency);
    checkWord("first read", addr, rdata, model[addr[busPkg::MemIdxBits+1:2]]);
    dataAccess(1'b0, addr, '0, '0, rdata, latency);
    checkWord("repeated read", addr, rdata, model[addr[busPkg::MemIdxBits+1:2]]);
    assert (latency == 1) begin
      passCnt++;
    end else begin
      $display("MISMATCH at %0t: hit latency %0d cycles, expected 1", $time, latency);
      failCnt++;
    end
    reportTest("hit latency", failsBefore);

    failsBefore = failCnt;
    fork
      runDataTraffic(MixedTests, 3);
      runFetchTraffic(MixedTests, 3);
    join
    reportTest("concurrent traffic", failsBefore);

    $display("checks passed: %0d, checks failed: %0d", passCnt, failCnt);
    if (failCnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* tb.f */
hw/cachePkg.sv
hw/busPkg.sv
hw/dataCache.sv
hw/instrCache.sv
hw/busArbiter.sv
hw/wordMemory.sv
hw/cacheTop.sv
tb/clockGen.sv
tb/cacheTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cacheTb -Mdir obj_dir -f tb.f
./obj_dir/VcacheTb > sim.log 2>&1
cat sim.log

if grep -qx "Everything OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
